// File: Makefile
# Verilator flow for the cache testbench

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module tb_cache

sim:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_cache -Mdir obj_dir -o sim_cache
	-./obj_dir/sim_cache > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: cache_controller.sv
module cache_controller (
    input  logic                                 clock,
    input  logic                                 reset_n,
    input  cache_pkg::cpu_req_t                  cpu_req,
    output logic [cache_pkg::DATA_WIDTH-1:0]     cpu_rdata,
    output logic                                 cpu_done,
    output cache_pkg::mem_req_t                  mem_req,
    input  logic                                 mem_ack,
    input  logic [cache_pkg::DATA_WIDTH-1:0]     mem_rdata,
    input  cache_pkg::lookup_t                   result,
    input  cache_pkg::tag_entry_t                next_entry0,
    input  cache_pkg::tag_entry_t                next_entry1,
    input  cache_pkg::tag_entry_t                read_entry0,
    input  cache_pkg::tag_entry_t                read_entry1,
    input  logic [cache_pkg::DATA_WIDTH-1:0]     read_data0,
    input  logic [cache_pkg::DATA_WIDTH-1:0]     read_data1,
    output logic [cache_pkg::INDEX_WIDTH-1:0]    index,
    output logic [cache_pkg::TAG_WIDTH-1:0]      req_tag,
    output logic                                 write_hit,
    output logic [cache_pkg::NUM_WAYS-1:0]       tag_write_en,
    output logic [cache_pkg::NUM_WAYS-1:0]       data_write_en,
    output cache_pkg::tag_entry_t                write_entry0,
    output cache_pkg::tag_entry_t                write_entry1,
    output logic [cache_pkg::DATA_WIDTH-1:0]     write_data
);

    import cache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        REREAD
    } state_t;

    state_t     state;
    cpu_req_t   req_q;       // Latched CPU request
    way_sel_t   victim_q;
    logic       accept;
    tag_entry_t victim_entry;
    tag_entry_t fill_entry;
    tag_entry_t kept0;
    tag_entry_t kept1;
    mem_req_t   wb_req;
    mem_req_t   fill_req;

    // CPU still holds the finished request while cpu_done is up
    assign accept = (state == IDLE) && !cpu_done && (cpu_req.rd || cpu_req.wr);

    assign index     = (state == IDLE) ? cpu_req.addr.index : req_q.addr.index;
    assign req_tag   = req_q.addr.tag;
    assign write_hit = req_q.wr;

    assign victim_entry = result.victim_way ? read_entry1 : read_entry0;

    always_comb
    begin
        wb_req            = '0;
        wb_req.wr         = 1'b1;
        wb_req.addr.tag   = victim_entry.tag;
        wb_req.addr.index = req_q.addr.index;
        wb_req.wdata      = result.victim_way ? read_data1 : read_data0;
        fill_req          = '0;
        fill_req.rd       = 1'b1;
        fill_req.addr     = req_q.addr;
    end

    // Line installed by a refill, and the neighbour with used cleared
    always_comb
    begin
        fill_entry       = '0;
        fill_entry.valid = 1'b1;
        fill_entry.used  = 1'b1;
        fill_entry.tag   = req_q.addr.tag;
        kept0            = read_entry0;
        kept0.used       = 1'b0;
        kept1            = read_entry1;
        kept1.used       = 1'b0;
    end

    always_comb
    begin
        tag_write_en  = '0;
        data_write_en = '0;
        write_entry0  = next_entry0;
        write_entry1  = next_entry1;
        write_data    = req_q.wdata;
        case (state)
            LOOKUP:
            begin
                if (result.hit)
                begin
                    tag_write_en = '1;    // Update used and dirty bits
                    if (req_q.wr)
                    begin
                        data_write_en[result.hit_way] = 1'b1;
                    end
                end
            end
            REFILL:
            begin
                if (mem_ack)
                begin
                    tag_write_en            = '1;
                    data_write_en[victim_q] = 1'b1;
                    write_data              = mem_rdata;
                    write_entry0            = (victim_q == 1'b0) ? fill_entry : kept0;
                    write_entry1            = (victim_q == 1'b1) ? fill_entry : kept1;
                end
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            state    <= IDLE;
            mem_req  <= '0;
            cpu_done <= 1'b0;
        end
        else
        begin
            cpu_done <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP:
                begin
                    if (result.hit)
                    begin
                        cpu_done <= 1'b1;
                        state    <= IDLE;
                    end
                    else if (result.victim_dirty)
                    begin
                        mem_req <= wb_req;
                        state   <= WRITEBACK;
                    end
                    else
                    begin
                        mem_req <= fill_req;
                        state   <= REFILL;
                    end
                end
                WRITEBACK:
                begin
                    if (mem_ack)
                    begin
                        mem_req <= fill_req;
                        state   <= REFILL;
                    end
                end
                REFILL:
                begin
                    if (mem_ack)
                    begin
                        mem_req <= '0;
                        state   <= REREAD;
                    end
                end
                REREAD: state <= LOOKUP;    // Store read sees the new line
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            req_q <= cpu_req;
        end
        if (state == LOOKUP)
        begin
            victim_q <= result.victim_way;
        end
        if (state == LOOKUP && result.hit)
        begin
            cpu_rdata <= result.hit_way ? read_data1 : read_data0;
        end
    end

    a_mem_one_op: assert property (
        @(posedge clock) disable iff (!reset_n)
        !(mem_req.rd && mem_req.wr));

    a_mem_hold: assert property (
        @(posedge clock) disable iff (!reset_n)
        (mem_req.rd || mem_req.wr) && !mem_ack |=> $stable(mem_req));

    // Used bits must always leave a victim to pick
    a_victim_free: assert property (
        @(posedge clock) disable iff (!reset_n)
        (state == LOOKUP) && !result.hit |-> result.any_used_clear);

endmodule

// File: cache_lookup.sv
module cache_lookup (
    input  logic [cache_pkg::TAG_WIDTH-1:0] req_tag,
    input  cache_pkg::tag_entry_t           entry0,
    input  cache_pkg::tag_entry_t           entry1,
    input  logic                            write_hit,   // Current request is a write
    output cache_pkg::lookup_t              result,
    output cache_pkg::tag_entry_t           next_entry0,
    output cache_pkg::tag_entry_t           next_entry1
);

    import cache_pkg::*;

    tag_entry_t            entry [NUM_WAYS];
    tag_entry_t            next  [NUM_WAYS];
    logic [NUM_WAYS-1:0]   way_hit;
    way_sel_t              victim;
    way_sel_t              accessed;

    assign entry[0]    = entry0;
    assign entry[1]    = entry1;
    assign next_entry0 = next[0];
    assign next_entry1 = next[1];

    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            way_hit[w] = entry[w].valid && (entry[w].tag == req_tag);
        end
    end

    // First way with used clear, way 0 when neither is clear
    assign victim   = way_sel_t'(entry0.used && !entry1.used);
    assign accessed = (|way_hit) ? way_sel_t'(way_hit[1]) : victim;

    always_comb
    begin
        result.hit            = |way_hit;
        result.hit_way        = way_sel_t'(way_hit[1]);
        result.victim_way     = victim;
        result.victim_dirty   = entry[victim].valid && entry[victim].dirty;
        result.any_used_clear = !entry0.used || !entry1.used;
    end

    // Accessed way becomes the used one and the other drops back
    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            next[w]      = entry[w];
            next[w].used = (accessed == way_sel_t'(w));
            if (write_hit && (|way_hit) && (accessed == way_sel_t'(w)))
            begin
                next[w].dirty = 1'b1;    // Write hit leaves the line dirty
            end
        end
    end

    // A tag is only installed after a miss, so one set never holds it twice
    always_comb
    begin
        assert final (!(way_hit[0] && way_hit[1]))
            else $error("cache_lookup: tag %0h hits in both ways", req_tag);
    end

endmodule

// File: cache_pkg.sv
package cache_pkg;

    localparam int ADDR_WIDTH  = 9;    // Word address
    localparam int DATA_WIDTH  = 32;
    localparam int INDEX_WIDTH = 3;
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH;
    localparam int NUM_SETS    = 1 << INDEX_WIDTH;
    localparam int NUM_WAYS    = 2;

    // Word address as seen by the cache
    typedef struct packed {
        logic [TAG_WIDTH-1:0]   tag;
        logic [INDEX_WIDTH-1:0] index;
    } cache_addr_t;

    // One way entry of the tag store
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic                 used;    // Set on the way touched last
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    typedef logic [$clog2(NUM_WAYS)-1:0] way_sel_t;

    // CPU request, held until cpu_done
    typedef struct packed {
        logic                  rd;
        logic                  wr;
        cache_addr_t           addr;
        logic [DATA_WIDTH-1:0] wdata;
    } cpu_req_t;

    // Memory request, held until mem_ack
    typedef struct packed {
        logic                  rd;
        logic                  wr;
        cache_addr_t           addr;
        logic [DATA_WIDTH-1:0] wdata;
    } mem_req_t;

    // Decode of both stored entries against the request tag
    typedef struct packed {
        logic     hit;
        way_sel_t hit_way;
        way_sel_t victim_way;
        logic     victim_dirty;      // Victim valid and dirty
        logic     any_used_clear;
    } lookup_t;

endpackage

// File: cache_top.sv
module cache_top (
    input  logic                              clock,
    input  logic                              reset_n,
    input  cache_pkg::cpu_req_t               cpu_req,
    output logic [cache_pkg::DATA_WIDTH-1:0]  cpu_rdata,
    output logic                              cpu_done,
    output cache_pkg::mem_req_t               mem_req,
    input  logic                              mem_ack,
    input  logic [cache_pkg::DATA_WIDTH-1:0]  mem_rdata
);

    import cache_pkg::*;

    logic [INDEX_WIDTH-1:0] index;
    logic [TAG_WIDTH-1:0]   req_tag;
    logic                   write_hit;
    logic [NUM_WAYS-1:0]    tag_write_en;
    logic [NUM_WAYS-1:0]    data_write_en;
    logic [DATA_WIDTH-1:0]  write_data;
    logic [DATA_WIDTH-1:0]  read_data0;
    logic [DATA_WIDTH-1:0]  read_data1;
    tag_entry_t             write_entry0;
    tag_entry_t             write_entry1;
    tag_entry_t             read_entry0;
    tag_entry_t             read_entry1;
    tag_entry_t             next_entry0;
    tag_entry_t             next_entry1;
    lookup_t                result;

    tag_store u_tag_store (
        .clock        (clock),
        .reset_n      (reset_n),
        .index        (index),
        .write_en     (tag_write_en),
        .write_entry0 (write_entry0),
        .write_entry1 (write_entry1),
        .read_entry0  (read_entry0),
        .read_entry1  (read_entry1)
    );

    data_store u_data_store (
        .clock      (clock),
        .index      (index),
        .write_en   (data_write_en),
        .write_data (write_data),
        .read_data0 (read_data0),
        .read_data1 (read_data1)
    );

    cache_lookup u_lookup (
        .req_tag     (req_tag),
        .entry0      (read_entry0),
        .entry1      (read_entry1),
        .write_hit   (write_hit),
        .result      (result),
        .next_entry0 (next_entry0),
        .next_entry1 (next_entry1)
    );

    cache_controller u_controller (
        .clock         (clock),
        .reset_n       (reset_n),
        .cpu_req       (cpu_req),
        .cpu_rdata     (cpu_rdata),
        .cpu_done      (cpu_done),
        .mem_req       (mem_req),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .result        (result),
        .next_entry0   (next_entry0),
        .next_entry1   (next_entry1),
        .read_entry0   (read_entry0),
        .read_entry1   (read_entry1),
        .read_data0    (read_data0),
        .read_data1    (read_data1),
        .index         (index),
        .req_tag       (req_tag),
        .write_hit     (write_hit),
        .tag_write_en  (tag_write_en),
        .data_write_en (data_write_en),
        .write_entry0  (write_entry0),
        .write_entry1  (write_entry1),
        .write_data    (write_data)
    );

endmodule

// File: data_store.sv
module data_store (
    input  logic                                 clock,
    input  logic [cache_pkg::INDEX_WIDTH-1:0]    index,
    input  logic [cache_pkg::NUM_WAYS-1:0]       write_en,
    input  logic [cache_pkg::DATA_WIDTH-1:0]     write_data,
    output logic [cache_pkg::DATA_WIDTH-1:0]     read_data0,
    output logic [cache_pkg::DATA_WIDTH-1:0]     read_data1
);

    import cache_pkg::*;

    logic [DATA_WIDTH-1:0] words   [NUM_WAYS][NUM_SETS];
    logic [DATA_WIDTH-1:0] rd_word [NUM_WAYS];

    assign read_data0 = rd_word[0];
    assign read_data1 = rd_word[1];

    // Plain synchronous-read RAM per way
    always_ff @(posedge clock)
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (write_en[w])
            begin
                words[w][index] <= write_data;
            end
            rd_word[w] <= words[w][index];
        end
    end

endmodule

// File: mem_model.sv
module mem_model (
    input  logic                                clock,
    input  logic                                reset_n,
    input  cache_pkg::mem_req_t                 mem_req,
    output logic                                mem_ack,
    output logic [cache_pkg::DATA_WIDTH-1:0]    mem_rdata,
    output int                                  read_count,
    output int                                  write_count,
    output logic [cache_pkg::ADDR_WIDTH-1:0]    last_wr_addr,
    output logic [cache_pkg::DATA_WIDTH-1:0]    last_wr_data
);

    import cache_pkg::*;

    localparam int MEM_WORDS   = 1 << ADDR_WIDTH;
    localparam int DRIVE_DELAY = 2;

    logic [DATA_WIDTH-1:0] words [MEM_WORDS];
    logic                  busy;         // A request is being served
    int                    wait_left;

    initial
    begin
        mem_ack      = 1'b0;
        mem_rdata    = '0;
        read_count   = 0;
        write_count  = 0;
        last_wr_addr = '0;
        last_wr_data = '0;
        busy         = 1'b0;
        wait_left    = 0;
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            words[a] = $urandom;
        end
        forever
        begin
            @(posedge clock);
            #DRIVE_DELAY;
            // Request seen with ack is finished and the cache has moved on
            if (mem_ack || !reset_n)
            begin
                mem_ack = 1'b0;
                busy    = 1'b0;
            end
            if (reset_n && (mem_req.rd || mem_req.wr))
            begin
                if (!busy)
                begin
                    busy      = 1'b1;
                    wait_left = $urandom_range(4, 1);    // 1 to 4 cycles
                end
                wait_left--;
                if (wait_left == 0)
                begin
                    if (mem_req.wr)
                    begin
                        words[mem_req.addr] = mem_req.wdata;
                        last_wr_addr        = mem_req.addr;
                        last_wr_data        = mem_req.wdata;
                        write_count++;
                    end
                    else
                    begin
                        mem_rdata = words[mem_req.addr];
                        read_count++;
                    end
                    mem_ack = 1'b1;
                end
            end
        end
    end

endmodule

// File: sim.f
cache_pkg.sv
tag_store.sv
data_store.sv
cache_lookup.sv
cache_controller.sv
cache_top.sv
mem_model.sv
tb_cache.sv

// File: tag_store.sv
module tag_store (
    input  logic                                  clock,
    input  logic                                  reset_n,
    input  logic [cache_pkg::INDEX_WIDTH-1:0]     index,
    input  logic [cache_pkg::NUM_WAYS-1:0]        write_en,
    input  cache_pkg::tag_entry_t                 write_entry0,
    input  cache_pkg::tag_entry_t                 write_entry1,
    output cache_pkg::tag_entry_t                 read_entry0,
    output cache_pkg::tag_entry_t                 read_entry1
);

    import cache_pkg::*;

    tag_entry_t entries  [NUM_WAYS][NUM_SETS];
    tag_entry_t wr_entry [NUM_WAYS];
    tag_entry_t rd_entry [NUM_WAYS];

    assign wr_entry[0]  = write_entry0;
    assign wr_entry[1]  = write_entry1;
    assign read_entry0  = rd_entry[0];
    assign read_entry1  = rd_entry[1];

    // Reset clears every valid bit of the flop array
    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                for (int s = 0; s < NUM_SETS; s++)
                begin
                    entries[w][s] <= '0;
                end
                rd_entry[w] <= '0;
            end
        end
        else
        begin
            for (int w = 0; w < NUM_WAYS; w++)
            begin
                if (write_en[w])
                begin
                    entries[w][index] <= wr_entry[w];
                end
                // Read returns the old entry on a same-edge write
                rd_entry[w] <= entries[w][index];
            end
        end
    end

endmodule

// File: tb_cache.sv
module tb_cache;

    import cache_pkg::*;

    localparam int          HALF_PERIOD    = 20;
    localparam int          DRIVE_DELAY    = 2;
    localparam logic [31:0] SEED           = 32'h976dcc04;
    localparam int          MEM_WORDS      = 1 << ADDR_WIDTH;
    localparam int          RANDOM_OPS     = 200;
    localparam int          DIRECTED_OPS   = 20;     // Accesses of the directed tests, rounded up
    localparam int          ACCESS_CYCLES  = 16;     // Writeback plus refill at the longest delay
    localparam int          TIMEOUT_CYCLES = (RANDOM_OPS + DIRECTED_OPS) * ACCESS_CYCLES;

    logic                   clock;
    logic                   reset_n;
    cpu_req_t               cpu_req;
    logic [DATA_WIDTH-1:0]  cpu_rdata;
    logic                   cpu_done;
    mem_req_t               mem_req;
    logic                   mem_ack;
    logic [DATA_WIDTH-1:0]  mem_rdata;
    int                     read_count;
    int                     write_count;
    logic [ADDR_WIDTH-1:0]  last_wr_addr;
    logic [DATA_WIDTH-1:0]  last_wr_data;

    logic [DATA_WIDTH-1:0]  shadow [MEM_WORDS];    // Memory as the CPU sees it
    int                     errors;
    int                     checks;
    int                     cycle_count = 0;

    cache_top uut (
        .clock     (clock),
        .reset_n   (reset_n),
        .cpu_req   (cpu_req),
        .cpu_rdata (cpu_rdata),
        .cpu_done  (cpu_done),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    mem_model u_mem (
        .clock        (clock),
        .reset_n      (reset_n),
        .mem_req      (mem_req),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .read_count   (read_count),
        .write_count  (write_count),
        .last_wr_addr (last_wr_addr),
        .last_wr_data (last_wr_data)
    );

    always #HALF_PERIOD clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
                                                        input logic [INDEX_WIDTH-1:0] index);
        return {tag, index};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("ERR at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    // One CPU request, held until cpu_done; cycles counts edges from the first one seeing it
    task automatic cpu_access(input logic is_write, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] wdata,
                              output logic [DATA_WIDTH-1:0] rdata, output int cycles);
        @(posedge clock);
        #DRIVE_DELAY;
        cpu_req.rd    = !is_write;
        cpu_req.wr    = is_write;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cycles        = 0;
        do
        begin
            @(posedge clock);
            #DRIVE_DELAY;
            cycles++;
        end
        while (!cpu_done);
        rdata   = cpu_rdata;
        cpu_req = '0;
        if (is_write)
        begin
            shadow[addr] = wdata;
        end
    endtask

    task automatic read_and_check(input string name, input logic [ADDR_WIDTH-1:0] addr,
                                  output int cycles);
        logic [DATA_WIDTH-1:0] rdata;
        cpu_access(1'b0, addr, '0, rdata, cycles);
        check_value(name, rdata, shadow[addr]);
    endtask

    task automatic write_word(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] data, output int cycles);
        logic [DATA_WIDTH-1:0] unused_rdata;
        cpu_access(1'b1, addr, data, unused_rdata, cycles);
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("%-16s finished, %0d errors", name, errors - start_errors);
    endtask

    task automatic cold_read_miss();
        int start_errors;
        int reads;
        int writes;
        int cycles;
        start_errors = errors;
        reads        = read_count;
        writes       = write_count;
        read_and_check("cpu_rdata", make_addr(6'h05, 3'd1), cycles);
        check_value("read_count", read_count, reads + 1);
        check_value("write_count", write_count, writes);
        report_test("cold read miss", start_errors);
    endtask

    task automatic write_then_read_hit();
        int                    start_errors;
        int                    reads;
        int                    writes;
        int                    cycles;
        logic [ADDR_WIDTH-1:0] addr;
        start_errors = errors;
        reads        = read_count;
        writes       = write_count;
        addr         = make_addr(6'h05, 3'd1);    // Resident since the cold read
        write_word(addr, $urandom, cycles);
        check_value("write latency", cycles, 2);
        read_and_check("cpu_rdata", addr, cycles);
        check_value("read latency", cycles, 2);
        check_value("read_count", read_count, reads);
        check_value("write_count", write_count, writes);
        report_test("write hit", start_errors);
    endtask

    task automatic lru_replacement();
        int                    start_errors;
        int                    reads;
        int                    cycles;
        logic [ADDR_WIDTH-1:0] addr_a;
        logic [ADDR_WIDTH-1:0] addr_b;
        start_errors = errors;
        addr_a       = make_addr(6'h0a, 3'd2);
        addr_b       = make_addr(6'h0b, 3'd2);
        read_and_check("cpu_rdata", addr_a, cycles);
        read_and_check("cpu_rdata", addr_b, cycles);
        read_and_check("cpu_rdata", addr_a, cycles);    // B is now least recently used
        read_and_check("cpu_rdata", make_addr(6'h0c, 3'd2), cycles);
        reads = read_count;
        read_and_check("cpu_rdata", addr_a, cycles);
        check_value("read_count", read_count, reads);
        read_and_check("cpu_rdata", addr_b, cycles);
        check_value("read_count", read_count, reads + 1);
        report_test("lru replacement", start_errors);
    endtask

    task automatic dirty_writeback();
        int                    start_errors;
        int                    writes;
        int                    cycles;
        logic [ADDR_WIDTH-1:0] addr_d;
        logic [DATA_WIDTH-1:0] data_d;
        start_errors = errors;
        addr_d       = make_addr(6'h14, 3'd5);
        data_d       = $urandom;
        write_word(addr_d, data_d, cycles);
        write_word(make_addr(6'h15, 3'd5), $urandom, cycles);
        writes = write_count;
        read_and_check("cpu_rdata", make_addr(6'h16, 3'd5), cycles);
        check_value("write_count", write_count, writes + 1);
        check_value("last_wr_addr", 32'(last_wr_addr), 32'(addr_d));
        check_value("last_wr_data", last_wr_data, data_d);
        read_and_check("cpu_rdata", addr_d, cycles);
        report_test("dirty writeback", start_errors);
    endtask

    // Tags 0x30 to 0x37 in sets 0, 3 and 6
    task automatic random_sequence();
        int                    start_errors;
        int                    pick;
        int                    cycles;
        logic [ADDR_WIDTH-1:0] addr;
        start_errors = errors;
        for (int n = 0; n < RANDOM_OPS; n++)
        begin
            pick = $urandom_range(23, 0);
            addr = make_addr(TAG_WIDTH'(48 + pick / 3), INDEX_WIDTH'(3 * (pick % 3)));
            if ($urandom_range(1, 0) == 1)
            begin
                write_word(addr, $urandom, cycles);
            end
            else
            begin
                read_and_check("cpu_rdata", addr, cycles);
            end
        end
        report_test("random sequence", start_errors);
    endtask

    initial
    begin
        clock   = 1'b0;
        reset_n = 1'b0;
        cpu_req = '0;
        errors  = 0;
        checks  = 0;
        void'($urandom(SEED));
        repeat (2) @(posedge clock);
        #DRIVE_DELAY;
        reset_n = 1'b1;
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            shadow[a] = u_mem.words[a];    // Start from the memory contents
        end
        cold_read_miss();
        write_then_read_hit();
        lru_replacement();
        dirty_writeback();
        random_sequence();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
